/* alu_unit.f */
logic/alu_pkg.sv
logic/alu_unit_ifs.sv
logic/alu_inverter.sv
logic/alu_add_cla_lh.sv
logic/alu_add_cla_uh.sv
logic/alu_comb.sv
logic/alu_regfile.sv
logic/alu_issue_ctrl.sv
logic/alu_unit_top.sv
tb/alu_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_unit_tb
LOG       ?= sim.log
FLAGS     ?= -j 0
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP LOG FLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f alu_unit.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/alu_unit_tb.sv */
// alu execution unit testbench
module alu_unit_tb import alu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int instr_depth    = 4;
    localparam int result_credits = 2;
    localparam int max_cycles     = 4000;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [15:0] instr;
    logic        instr_credit;
    logic        result_valid;
    logic [15:0] result_data;
    logic [2:0]  result_rd;
    logic        result_carry;
    logic        result_credit;

    // reference model state and expected results
    logic [15:0] m_regs [8];
    logic        m_carry;
    logic [15:0] exp_data [$];
    logic [2:0]  exp_rd [$];
    logic        exp_carry [$];

    int cyc;
    int errors;
    int checks;
    int sent;
    int credit_pulses;
    int results_seen;
    int returned;
    int accept_cyc;
    int last_result_cyc;
    bit hold;

    alu_unit_top #(
        .REG_WIDTH     (16),
        .INSTR_DEPTH   (instr_depth),
        .RESULT_CREDITS(result_credits)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_rd    (result_rd),
        .result_carry (result_carry),
        .result_credit(result_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // consumer returns one credit per absorbed result unless held back
    always @(posedge clk) begin
        if (reset) begin
            result_credit <= 1'b0;
        end else if (!hold && returned < results_seen) begin
            result_credit <= 1'b1;
            returned++;
        end else begin
            result_credit <= 1'b0;
        end
    end

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // result monitor
    always @(negedge clk) begin
        if (!reset) begin
            if (instr_credit) begin
                credit_pulses++;
            end
            if (result_valid) begin
                results_seen++;
                last_result_cyc = cyc;
                if (exp_data.size() == 0) begin
                    $display("At %0t a result came out with no instruction outstanding", $time);
                    errors++;
                end else begin
                    check_val("result_data", result_data, exp_data.pop_front());
                    check_val("result_rd", 16'(result_rd), 16'(exp_rd.pop_front()));
                    check_val("result_carry", 16'(result_carry), 16'(exp_carry.pop_front()));
                end
                if (results_seen - returned > result_credits) begin
                    $display("At %0t more results came out than credits granted", $time);
                    errors++;
                end
            end
        end
    end

    function automatic logic [15:0] rform(alu_opcode_e op, int rd, int rs1, int rs2);
        return {op, 1'b0, 3'(rd), 3'(rs1), 3'(rs2), 2'b00};
    endfunction

    function automatic logic [15:0] iform(alu_opcode_e op, int rd, int rs1, int imm);
        return {op, 1'b1, 3'(rd), 3'(rs1), 5'(imm)};
    endfunction

    task automatic model_exec(input logic [15:0] w);
        alu_opcode_e op;
        logic [15:0] a;
        logic [15:0] b2;
        logic [16:0] s;
        op = alu_opcode_e'(w[15:12]);
        a  = m_regs[w[7:5]];
        b2 = w[11] ? {{11{w[4]}}, w[4:0]} : m_regs[w[4:2]];
        case (op)
            OP_ADD:  s = {1'b0, a} + {1'b0, b2};
            OP_ADC:  s = {1'b0, a} + {1'b0, b2} + 17'(m_carry);
            OP_SUB:  s = {1'b0, a} + {1'b0, 16'(~b2 + 16'd1)};
            OP_NEG:  s = {1'b0, 16'(~b2 + 16'd1)};
            OP_AND:  s = {1'b0, a & b2};
            OP_OR:   s = {1'b0, a | b2};
            OP_XOR:  s = {1'b0, a ^ b2};
            OP_NAND: s = {1'b0, ~(a & b2)};
            OP_NOR:  s = {1'b0, ~(a | b2)};
            OP_NOT:  s = {1'b0, ~b2};
            default: s = '0;
        endcase
        if (op inside {OP_ADD, OP_ADC, OP_SUB, OP_NEG}) begin
            m_carry = s[16];
        end
        // r0 stays zero
        if (w[10:8] != 3'd0) begin
            m_regs[w[10:8]] = s[15:0];
        end
        exp_data.push_back(s[15:0]);
        exp_rd.push_back(w[10:8]);
        exp_carry.push_back(s[16]);
    endtask

    // waits for an instruction credit before driving
    task automatic send(input logic [15:0] w);
        while (instr_depth + credit_pulses - sent <= 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        sent++;
        accept_cyc = cyc + 2;
        model_exec(w);
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    function automatic int rnd_reg();
        return $urandom_range(7, 0);
    endfunction

    function automatic int rnd_rd();
        return $urandom_range(7, 1);
    endfunction

    function automatic int rnd_imm();
        return $urandom_range(31, 0);
    endfunction

    // random values through add chains
    task automatic load_regs();
        for (int k = 1; k < 8; k++) begin
            send(iform(OP_ADD, k, 0, rnd_imm()));
            repeat (3) begin
                repeat (4) send(rform(OP_ADD, k, k, k));
                send(iform(OP_ADD, k, k, rnd_imm()));
            end
        end
        drain();
    endtask

    task automatic reset_test();
        int e0;
        e0 = errors;
        repeat (20) begin
            @(negedge clk);
            if (result_valid || instr_credit) begin
                $display("At %0t an output toggled with nothing sent", $time);
                errors++;
            end
        end
        send(iform(OP_ADD, 1, 0, 5));
        drain();
        // registered two edges after the sampling edge
        check_val("result latency", 16'(last_result_cyc - accept_cyc), 16'd2);
        $display("reset test done, errors %0d", errors - e0);
    endtask

    task automatic logic_test();
        alu_opcode_e lops [6];
        int e0;
        e0 = errors;
        lops = '{OP_AND, OP_OR, OP_XOR, OP_NAND, OP_NOR, OP_NOT};
        load_regs();
        foreach (lops[i]) begin
            repeat (3) begin
                send(rform(lops[i], rnd_rd(), rnd_reg(), rnd_reg()));
                send(iform(lops[i], rnd_rd(), rnd_reg(), rnd_imm()));
            end
        end
        drain();
        $display("logic test done, errors %0d", errors - e0);
    endtask

    task automatic arith_test();
        int e0;
        e0 = errors;
        send(iform(OP_ADD, 1, 0, -1));
        send(rform(OP_ADD, 2, 1, 1));
        send(rform(OP_SUB, 3, 1, 2));
        send(rform(OP_NEG, 4, 0, 2));
        send(iform(OP_SUB, 5, 0, 3));
        // adc chain fed by an overflowing add
        send(iform(OP_ADD, 5, 1, 1));
        send(iform(OP_ADC, 6, 0, 0));
        send(rform(OP_ADC, 6, 6, 1));
        send(rform(OP_ADC, 7, 1, 1));
        repeat (12) begin
            send(rform(alu_opcode_e'($urandom_range(3, 0)), rnd_rd(), rnd_reg(), rnd_reg()));
        end
        drain();
        $display("arithmetic test done, errors %0d", errors - e0);
    endtask

    task automatic dependency_test();
        int e0;
        int prev;
        int rd;
        e0 = errors;
        prev = 1;
        repeat (10) begin
            rd = rnd_rd();
            send(rform(alu_opcode_e'($urandom_range(9, 0)), rd, prev, prev));
            prev = rd;
        end
        drain();
        $display("dependency test done, errors %0d", errors - e0);
    endtask

    task automatic backpressure_test();
        int e0;
        int r0;
        e0 = errors;
        r0 = results_seen;
        hold = 1'b1;
        for (int k = 1; k < 7; k++) begin
            send(iform(OP_ADD, k, 0, k));
        end
        repeat (30) @(negedge clk);
        check_val("results under back-pressure", 16'(results_seen - r0), 16'(result_credits));
        check_val("instruction credits left", 16'(instr_depth + credit_pulses - sent), 16'd0);
        hold = 1'b0;
        drain();
        $display("back-pressure test done, errors %0d", errors - e0);
    endtask

    task automatic credit_test();
        int e0;
        e0 = errors;
        hold = 1'b1;
        repeat (instr_depth + result_credits) begin
            send(rform(OP_XOR, rnd_rd(), rnd_reg(), rnd_reg()));
        end
        repeat (20) @(negedge clk);
        check_val("instruction credits left", 16'(instr_depth + credit_pulses - sent), 16'd0);
        hold = 1'b0;
        drain();
        repeat (10) @(negedge clk);
        check_val("instr_credit pulses", 16'(credit_pulses), 16'(sent));
        $display("credit test done, errors %0d", errors - e0);
    endtask

    initial begin
        process_seed();
        reset         = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        result_credit = 1'b0;
        hold          = 1'b0;
        cyc           = 0;
        errors        = 0;
        checks        = 0;
        sent          = 0;
        credit_pulses = 0;
        results_seen  = 0;
        returned      = 0;
        m_carry       = 1'b0;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        reset_test();
        logic_test();
        arith_test();
        dependency_test();
        backpressure_test();
        credit_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    function automatic void process_seed();
        void'($urandom(67548));
    endfunction

endmodule : alu_unit_tb

/* logic/alu_unit_top.sv */
// alu execution unit top
module alu_unit_top import alu_pkg::*; #(
    parameter int REG_WIDTH      = data_width,
    parameter int INSTR_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    // instruction stream
    input  logic                          instr_valid,
    input  logic [$bits(alu_instr_u)-1:0] instr,
    output logic                          instr_credit,
    // result stream
    output logic                          result_valid,
    output logic [REG_WIDTH-1:0]          result_data,
    output logic [reg_addr_width-1:0]     result_rd,
    output logic                          result_carry,
    input  logic                          result_credit
);
    alu_op_if #(.REG_WIDTH(REG_WIDTH)) op_if ();
    alu_rf_if #(.REG_WIDTH(REG_WIDTH)) rf_if ();

    alu_issue_ctrl #(
        .REG_WIDTH     (REG_WIDTH),
        .INSTR_DEPTH   (INSTR_DEPTH),
        .RESULT_CREDITS(RESULT_CREDITS)
    ) u_issue (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (alu_instr_u'(instr)),
        .instr_credit (instr_credit),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_rd    (result_rd),
        .result_carry (result_carry),
        .result_credit(result_credit),
        .rf           (rf_if),
        .op           (op_if)
    );

    alu_regfile #(
        .REG_WIDTH(REG_WIDTH)
    ) u_regfile (
        .clk  (clk),
        .reset(reset),
        .rf   (rf_if)
    );

    alu_comb #(
        .REG_WIDTH(REG_WIDTH)
    ) u_alu (
        .op(op_if)
    );

endmodule : alu_unit_top

/* logic/alu_issue_ctrl.sv */
// instruction queue and issue control
module alu_issue_ctrl import alu_pkg::*; #(
    parameter int REG_WIDTH      = data_width,
    parameter int INSTR_DEPTH    = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  alu_instr_u                instr,
    output logic                      instr_credit,
    output logic                      result_valid,
    output logic [REG_WIDTH-1:0]      result_data,
    output logic [reg_addr_width-1:0] result_rd,
    output logic                      result_carry,
    input  logic                      result_credit,
    alu_rf_if.ctrl                    rf,
    alu_op_if.issue                   op
);
    localparam int ptr_width = $clog2(INSTR_DEPTH);
    localparam int cnt_width = $clog2(INSTR_DEPTH + 1);
    localparam int crd_width = $clog2(RESULT_CREDITS + 1);

    alu_instr_u                queue [INSTR_DEPTH];
    logic [ptr_width-1:0]      wr_ptr;
    logic [ptr_width-1:0]      rd_ptr;
    logic [cnt_width-1:0]      count;
    logic [crd_width-1:0]      credits;
    alu_instr_u                head;
    alu_ctrl_entry_t           entry;
    logic                      rs1_busy;
    logic                      rs2_busy;
    logic                      carry_hazard;
    logic                      issue;
    logic [REG_WIDTH-1:0]      op2;
    logic                      carry_flag;
    // issue stage
    logic                      iss_valid;
    logic [reg_addr_width-1:0] iss_rd;
    logic                      iss_wr_carry;
    logic [REG_WIDTH-1:0]      iss_a;
    logic [REG_WIDTH-1:0]      iss_b;
    alu_ctrl_t                 iss_ctrl;
    logic                      iss_cin;
    // write-back stage
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_rd;
    logic                      wb_wr_carry;
    logic [REG_WIDTH-1:0]      wb_data;
    logic                      wb_carry;

    function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(INSTR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head  = queue[rd_ptr];
    assign entry = alu_ctrl_table[head.r.opcode];

    // stall on any nonzero source still owned by the issue or wb stage
    assign rs1_busy = (head.r.rs1 != '0) &&
                      ((iss_valid && iss_rd == head.r.rs1) || (wb_valid && wb_rd == head.r.rs1));
    assign rs2_busy = !head.r.imm && (head.r.rs2 != '0) &&
                      ((iss_valid && iss_rd == head.r.rs2) || (wb_valid && wb_rd == head.r.rs2));
    assign carry_hazard = (head.r.opcode == OP_ADC) &&
                          ((iss_valid && iss_wr_carry) || (wb_valid && wb_wr_carry));

    assign issue = (count != '0) && !rs1_busy && !rs2_busy && !carry_hazard && (credits != '0);

    assign rf.rs1_addr = head.r.rs1;
    assign rf.rs2_addr = head.r.rs2;
    assign op2 = head.r.imm ? {{(REG_WIDTH - 5){head.i.imm5[4]}}, head.i.imm5} : rf.rs2_data;

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            queue[wr_ptr] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credits      <= crd_width'(RESULT_CREDITS);
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count        <= count + cnt_width'(instr_valid) - cnt_width'(issue);
            credits      <= credits + crd_width'(result_credit) - crd_width'(issue);
            instr_credit <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid    <= 1'b0;
            iss_rd       <= '0;
            iss_wr_carry <= 1'b0;
            wb_valid     <= 1'b0;
            wb_rd        <= '0;
            wb_wr_carry  <= 1'b0;
            carry_flag   <= 1'b0;
        end else begin
            iss_valid    <= issue;
            iss_rd       <= head.r.rd;
            iss_wr_carry <= issue && entry.wr_carry;
            wb_valid     <= iss_valid;
            wb_rd        <= iss_rd;
            wb_wr_carry  <= iss_wr_carry;
            if (wb_valid && wb_wr_carry) begin
                carry_flag <= wb_carry;
            end
        end
    end

    // operands and alu results
    always_ff @(posedge clk) begin
        if (issue) begin
            iss_a    <= op2;
            iss_b    <= rf.rs1_data;
            iss_ctrl <= entry.ctrl;
            iss_cin  <= (head.r.opcode == OP_ADC) && carry_flag;
        end
        wb_data  <= op.out;
        wb_carry <= op.cout;
    end

    assign op.a    = iss_a;
    assign op.b    = iss_b;
    assign op.ctrl = iss_ctrl;
    assign op.cin  = iss_cin;

    assign rf.wr_en   = wb_valid;
    assign rf.wr_addr = wb_rd;
    assign rf.wr_data = wb_data;

    assign result_valid = wb_valid;
    assign result_data  = wb_data;
    assign result_rd    = wb_rd;
    assign result_carry = wb_carry;

endmodule : alu_issue_ctrl

/* logic/alu_regfile.sv */
// alu register file
module alu_regfile import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
) (
    input logic   clk,
    input logic   reset,
    alu_rf_if.rf  rf
);
    localparam int num_regs = 2 ** reg_addr_width;

    logic [REG_WIDTH-1:0] regs [num_regs];

    // r0 is hardwired to zero
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && (rf.wr_addr != '0)) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

endmodule : alu_regfile

/* logic/alu_comb.sv */
// combinational alu
module alu_comb import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
) (
    alu_op_if.alu op
);
    logic [REG_WIDTH-1:0] inv_a;
    logic [REG_WIDTH-1:0] b_en;
    logic [REG_WIDTH-1:0] prop;
    logic [REG_WIDTH-1:0] cgen_raw;
    logic [REG_WIDTH-1:0] cgen;
    logic [REG_WIDTH-1:0] sum;
    logic [REG_WIDTH-1:0] out_pre;

    alu_inverter #(
        .REG_WIDTH(REG_WIDTH)
    ) inv0 (
        .a      (op.a),
        .twos_en(op.ctrl.twos_en),
        .all_en (op.ctrl.all_en),
        .inv_a  (inv_a)
    );

    // b is dropped for the single-operand ops
    assign b_en = op.b & ~{REG_WIDTH{op.ctrl.all_en}};

    alu_add_cla_lh #(
        .REG_WIDTH(REG_WIDTH)
    ) cla_lh_0 (
        .a      (inv_a),
        .b      (b_en),
        .cgen_en(op.ctrl.cgen_en),
        .prop   (prop),
        .cgen   (cgen_raw)
    );

    // a | b is generate or propagate
    assign cgen = cgen_raw | (prop & {REG_WIDTH{op.ctrl.or_en}});

    alu_add_cla_uh #(
        .REG_WIDTH(REG_WIDTH)
    ) cla_uh_0 (
        .prop    (prop),
        .cgen    (cgen),
        .cin     (op.cin),
        .carry_en(op.ctrl.carry_en),
        .sum     (sum),
        .cout    (op.cout)
    );

    // output select then invert array
    assign out_pre = (sum & {REG_WIDTH{op.ctrl.sum_sel}})
                   | (cgen & {REG_WIDTH{op.ctrl.cgen_sel}});
    assign op.out  = out_pre ^ {REG_WIDTH{op.ctrl.out_inv}};

endmodule : alu_comb

/* logic/alu_add_cla_uh.sv */
// lookahead adder upper half
module alu_add_cla_uh import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
) (
    input  logic [REG_WIDTH-1:0] prop,
    input  logic [REG_WIDTH-1:0] cgen,
    input  logic                 cin,
    input  logic                 carry_en,
    output logic [REG_WIDTH-1:0] sum,
    output logic                 cout
);
    logic [REG_WIDTH:0] c;

    assign c[0] = cin;

    // full lookahead inside each nibble, ripple between nibbles
    for (genvar g = 0; g < REG_WIDTH / 4; g++) begin : g_grp
        localparam int base = 4 * g;
        logic [3:0] p;
        logic [3:0] gn;

        assign p  = prop[base+:4];
        assign gn = cgen[base+:4];

        assign c[base+1] = gn[0] | (p[0] & c[base]);
        assign c[base+2] = gn[1] | (p[1] & gn[0]) | (&p[1:0] & c[base]);
        assign c[base+3] = gn[2] | (p[2] & gn[1]) | (&p[2:1] & gn[0])
                         | (&p[2:0] & c[base]);
        assign c[base+4] = gn[3] | (p[3] & gn[2]) | (&p[3:2] & gn[1])
                         | (&p[3:1] & gn[0]) | (&p[3:0] & c[base]);
    end

    // without carries the sum is just the xor of the operands
    assign sum  = prop ^ (c[REG_WIDTH-1:0] & {REG_WIDTH{carry_en}});
    assign cout = c[REG_WIDTH] & carry_en;

endmodule : alu_add_cla_uh

/* logic/alu_add_cla_lh.sv */
// lookahead adder lower half
module alu_add_cla_lh import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
) (
    input  logic [REG_WIDTH-1:0] a,
    input  logic [REG_WIDTH-1:0] b,
    input  logic                 cgen_en,
    output logic [REG_WIDTH-1:0] prop,
    output logic [REG_WIDTH-1:0] cgen
);
    logic [REG_WIDTH-1:0] gen_raw;

    // per-bit propagate, also the carry-free sum
    assign prop = a ^ b;

    assign gen_raw = a & b;

    // generate terms only pass when enabled
    assign cgen = gen_raw & {REG_WIDTH{cgen_en}};

endmodule : alu_add_cla_lh

/* logic/alu_inverter.sv */
// alu operand inverter
module alu_inverter import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
) (
    input  logic [REG_WIDTH-1:0] a,
    input  logic                 twos_en,
    input  logic                 all_en,
    output logic [REG_WIDTH-1:0] inv_a
);
    logic [REG_WIDTH-1:0] not_a;
    logic [REG_WIDTH-1:0] neg_a;
    logic [REG_WIDTH-1:0] inc_c;

    assign not_a    = ~a;
    assign inc_c[0] = 1'b1;

    // increment chain on ~a for the negate
    for (genvar i = 0; i < REG_WIDTH; i++) begin : g_inc
        assign neg_a[i] = not_a[i] ^ inc_c[i];
        if (i < REG_WIDTH - 1) begin : g_carry
            assign inc_c[i+1] = not_a[i] & inc_c[i];
        end
    end

    // negate wins over plain invert
    always_comb begin
        if (twos_en) begin
            inv_a = neg_a;
        end else if (all_en) begin
            inv_a = not_a;
        end else begin
            inv_a = a;
        end
    end

endmodule : alu_inverter

/* logic/alu_unit_ifs.sv */
// alu operand and register file interfaces
interface alu_op_if import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
);
    logic [REG_WIDTH-1:0] a;
    logic [REG_WIDTH-1:0] b;
    alu_ctrl_t            ctrl;
    logic                 cin;
    logic [REG_WIDTH-1:0] out;
    logic                 cout;

    modport issue (output a, b, ctrl, cin, input out, cout);
    modport alu (input a, b, ctrl, cin, output out, cout);
endinterface : alu_op_if

interface alu_rf_if import alu_pkg::*; #(
    parameter int REG_WIDTH = data_width
);
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [REG_WIDTH-1:0]      rs1_data;
    logic [REG_WIDTH-1:0]      rs2_data;
    logic                      wr_en;
    logic [reg_addr_width-1:0] wr_addr;
    logic [REG_WIDTH-1:0]      wr_data;

    modport ctrl (output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data, input rs1_data, rs2_data);
    modport rf (input rs1_addr, rs2_addr, wr_en, wr_addr, wr_data, output rs1_data, rs2_data);
endinterface : alu_rf_if

/* logic/alu_pkg.sv */
// alu unit shared definitions
package alu_pkg;

    localparam int data_width     = 16;
    localparam int reg_addr_width = 3;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_ADC  = 4'h1,
        OP_SUB  = 4'h2,
        OP_NEG  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_NAND = 4'h7,
        OP_NOR  = 4'h8,
        OP_NOT  = 4'h9
    } alu_opcode_e;

    // register form, imm = 0
    typedef struct packed {
        alu_opcode_e               opcode;
        logic                      imm;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [1:0]                pad;
    } alu_rform_t;

    // immediate form, imm = 1
    typedef struct packed {
        alu_opcode_e               opcode;
        logic                      imm;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs1;
        logic [4:0]                imm5;
    } alu_iform_t;

    typedef union packed {
        alu_rform_t r;
        alu_iform_t i;
    } alu_instr_u;

    // same bit order as the raw alu control byte
    typedef struct packed {
        logic twos_en;
        logic all_en;
        logic cgen_en;
        logic or_en;
        logic carry_en;
        logic sum_sel;
        logic cgen_sel;
        logic out_inv;
    } alu_ctrl_t;

    typedef struct packed {
        alu_ctrl_t ctrl;
        logic      wr_carry;
    } alu_ctrl_entry_t;

    // unused opcodes drive a zero result
    localparam alu_ctrl_entry_t alu_ctrl_table [16] = '{
        OP_ADD:  '{ctrl: 8'b0010_1100, wr_carry: 1'b1},
        OP_ADC:  '{ctrl: 8'b0010_1100, wr_carry: 1'b1},
        OP_SUB:  '{ctrl: 8'b1010_1100, wr_carry: 1'b1},
        OP_NEG:  '{ctrl: 8'b1110_1100, wr_carry: 1'b1},
        OP_AND:  '{ctrl: 8'b0010_0010, wr_carry: 1'b0},
        OP_OR:   '{ctrl: 8'b0011_0010, wr_carry: 1'b0},
        OP_XOR:  '{ctrl: 8'b0000_0100, wr_carry: 1'b0},
        OP_NAND: '{ctrl: 8'b0010_0011, wr_carry: 1'b0},
        OP_NOR:  '{ctrl: 8'b0011_0011, wr_carry: 1'b0},
        OP_NOT:  '{ctrl: 8'b0100_0100, wr_carry: 1'b0},
        default: '{ctrl: 8'b0000_0000, wr_carry: 1'b0}
    };

endpackage : alu_pkg
